// ==== design/ccx_defines.svh ====
`ifndef CCX_DEFINES_SVH
`define CCX_DEFINES_SVH

// Timer region in the core complex address map.
`define CCX_MMIO_BASE 32'h0000_1000
`define CCX_MMIO_SIZE 32'h0000_0100

// Word offsets of the timer registers inside the region.
`define CCX_OFF_MTIME_LO    32'd0
`define CCX_OFF_MTIME_HI    32'd4
`define CCX_OFF_MTIMECMP_LO 32'd8
`define CCX_OFF_MTIMECMP_HI 32'd12

// All ones keeps the interrupt low until software programs a compare value.
`define CCX_MTIMECMP_RESET 64'hffff_ffff_ffff_ffff

`endif

// ==== design/ccx_pkg.sv ====
package ccx_pkg;

    // Bus address or data word.
    typedef logic [31:0] word_t;

    // Timer and counter value.
    typedef logic [63:0] dword_t;

    // MMIO bridge FSM states.
    typedef enum logic [1:0] {
        BR_IDLE  = 2'd0, // Waiting for a host strobe.
        BR_ISSUE = 2'd1, // Request on the memory bus.
        BR_RESP  = 2'd2  // Response back to the host.
    } bridge_state_e;

endpackage

// ==== design/ccx_memif.sv ====
`timescale 1ns/1ps

interface ccx_memif;
    import ccx_pkg::*;

    logic  req;   // One-cycle request strobe.
    logic  wen;   // Write enable.
    word_t addr;  // Word address.
    word_t wdata; // Write data.

    logic  gnt;   // Request accepted.
    word_t rdata; // Registered read data.
    logic  error; // Registered error response.

    // Bus master side.
    modport mst (
        output req, wen, addr, wdata,
        input  gnt, rdata, error
    );

    // Register block side.
    modport rsp (
        input  req, wen, addr, wdata,
        output gnt, rdata, error
    );

endinterface

// ==== design/ccx_mmio_bridge.sv ====
`timescale 1ns/1ps

module ccx_mmio_bridge (
    input  logic          f_clk,
    input  logic          g_resetn,

    input  logic          host_req,   // Single-cycle access strobe.
    input  logic          host_wen,
    input  ccx_pkg::word_t host_addr,
    input  ccx_pkg::word_t host_wdata,

    output logic          host_rsp,   // Single-cycle response strobe.
    output ccx_pkg::word_t host_rdata,
    output logic          host_error,

    ccx_memif.mst         mem
);
    import ccx_pkg::*;

    bridge_state_e state;
    bridge_state_e state_n;

    // Access captured from the host strobe.
    logic  wen_q;
    word_t addr_q;
    word_t wdata_q;

    logic  accept;

    // Strobes are only taken in idle.
    assign accept = (state == BR_IDLE) && host_req;

    always_comb begin
        state_n = state;
        case (state)
            BR_IDLE: begin
                if (host_req) begin
                    state_n = BR_ISSUE;
                end
            end
            BR_ISSUE: begin
                if (mem.gnt) begin // Always taken in practice.
                    state_n = BR_RESP;
                end
            end
            BR_RESP: begin
                state_n = BR_IDLE;
            end
            default: begin
                state_n = BR_IDLE;
            end
        endcase
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            state <= BR_IDLE;
        end else begin
            state <= state_n;
        end
    end

    always_ff @(posedge f_clk) begin
        if (accept) begin
            wen_q   <= host_wen;
            addr_q  <= host_addr;
            wdata_q <= host_wdata;
        end
    end

    // One request cycle per access.
    assign mem.req   = (state == BR_ISSUE);
    assign mem.wen   = wen_q;
    assign mem.addr  = addr_q;
    assign mem.wdata = wdata_q;

    // Responder holds its result until the next request.
    assign host_rsp   = (state == BR_RESP);
    assign host_rdata = mem.rdata;
    assign host_error = mem.error;

endmodule

// ==== design/ccx_mmio.sv ====
`timescale 1ns/1ps

`include "ccx_defines.svh"

module ccx_mmio (
    input  logic            f_clk,
    input  logic            g_resetn,

    ccx_memif.rsp           mmio,            // Internal memory bus.

    output logic            timer_interrupt, // Registered mtime >= mtimecmp.
    output ccx_pkg::dword_t ctr_time         // Current mtime.
);
    import ccx_pkg::*;

    // Only the offset bits below the region size are decoded.
    localparam word_t OFF_MASK = `CCX_MMIO_SIZE - 1;

    word_t  offset;

    dword_t mtime;
    dword_t mtimecmp;

    logic   wr_mtime_lo;
    logic   wr_mtime_hi;
    logic   wr_mtimecmp_lo;
    logic   wr_mtimecmp_hi;

    word_t  rdata_n;
    logic   error_n;

    // Every request is taken in its own cycle.
    assign mmio.gnt = 1'b1;

    assign offset = (mmio.addr - `CCX_MMIO_BASE) & OFF_MASK;

    assign wr_mtime_lo    = mmio.req && mmio.wen && (offset == `CCX_OFF_MTIME_LO);
    assign wr_mtime_hi    = mmio.req && mmio.wen && (offset == `CCX_OFF_MTIME_HI);
    assign wr_mtimecmp_lo = mmio.req && mmio.wen && (offset == `CCX_OFF_MTIMECMP_LO);
    assign wr_mtimecmp_hi = mmio.req && mmio.wen && (offset == `CCX_OFF_MTIMECMP_HI);

    // Free running time base, a write replaces one half.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mtime <= '0;
        end else if (wr_mtime_hi) begin
            mtime <= {mmio.wdata, mtime[31:0]};
        end else if (wr_mtime_lo) begin
            mtime <= {mtime[63:32], mmio.wdata};
        end else begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mtimecmp <= `CCX_MTIMECMP_RESET;
        end else if (wr_mtimecmp_hi) begin
            mtimecmp <= {mmio.wdata, mtimecmp[31:0]};
        end else if (wr_mtimecmp_lo) begin
            mtimecmp <= {mtimecmp[63:32], mmio.wdata};
        end
    end

    // Unsigned compare, one cycle late.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            timer_interrupt <= 1'b0;
        end else begin
            timer_interrupt <= (mtime >= mtimecmp);
        end
    end

    // Read data is the value before any write in the same cycle.
    always_comb begin
        rdata_n = '0;
        error_n = 1'b0;
        case (offset)
            `CCX_OFF_MTIME_LO:    rdata_n = mtime[31:0];
            `CCX_OFF_MTIME_HI:    rdata_n = mtime[63:32];
            `CCX_OFF_MTIMECMP_LO: rdata_n = mtimecmp[31:0];
            `CCX_OFF_MTIMECMP_HI: rdata_n = mtimecmp[63:32];
            default:              error_n = 1'b1; // Unmapped or misaligned.
        endcase
    end

    // Response holds until the next request.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            mmio.rdata <= '0;
            mmio.error <= 1'b0;
        end else if (mmio.req) begin
            mmio.rdata <= rdata_n;
            mmio.error <= error_n;
        end
    end

    assign ctr_time = mtime;

endmodule

// ==== design/ccx_counters.sv ====
`timescale 1ns/1ps

module ccx_counters (
    input  logic            f_clk,
    input  logic            g_resetn,

    input  logic            instr_ret,  // Instruction retired this cycle.
    input  logic            inhibit_cy, // Freeze the cycle counter.
    input  logic            inhibit_ir, // Freeze the instret counter.

    output ccx_pkg::dword_t ctr_cycle,
    output ccx_pkg::dword_t ctr_instret
);
    import ccx_pkg::*;

    logic cycle_inc;
    logic instret_inc;

    assign cycle_inc   = !inhibit_cy;
    assign instret_inc = instr_ret && !inhibit_ir;

    // Cycle counter.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            ctr_cycle <= '0;
        end else if (cycle_inc) begin
            ctr_cycle <= ctr_cycle + dword_t'(1);
        end
    end

    // Retired instruction counter.
    always_ff @(posedge f_clk) begin
        if (!g_resetn) begin
            ctr_instret <= '0;
        end else if (instret_inc) begin
            ctr_instret <= ctr_instret + dword_t'(1);
        end
    end

endmodule

// ==== design/ccx_timer_top.sv ====
`timescale 1ns/1ps

module ccx_timer_top (
    input  logic            f_clk,
    input  logic            g_resetn,

    // Host register access.
    input  logic            host_req,
    input  logic            host_wen,
    input  ccx_pkg::word_t  host_addr,
    input  ccx_pkg::word_t  host_wdata,
    output logic            host_rsp,
    output ccx_pkg::word_t  host_rdata,
    output logic            host_error,

    // Counter controls.
    input  logic            instr_ret,
    input  logic            inhibit_cy,
    input  logic            inhibit_ir,

    output logic            timer_interrupt,
    output ccx_pkg::dword_t ctr_time,
    output ccx_pkg::dword_t ctr_cycle,
    output ccx_pkg::dword_t ctr_instret
);

    ccx_memif memif (); // Bridge to timer registers.

    ccx_mmio_bridge u_bridge (
        .f_clk      (f_clk),
        .g_resetn   (g_resetn),
        .host_req   (host_req),
        .host_wen   (host_wen),
        .host_addr  (host_addr),
        .host_wdata (host_wdata),
        .host_rsp   (host_rsp),
        .host_rdata (host_rdata),
        .host_error (host_error),
        .mem        (memif.mst)
    );

    ccx_mmio u_mmio (
        .f_clk           (f_clk),
        .g_resetn        (g_resetn),
        .mmio            (memif.rsp),
        .timer_interrupt (timer_interrupt),
        .ctr_time        (ctr_time)
    );

    // Performance counters, read as CSRs by the core.
    ccx_counters u_counters (
        .f_clk       (f_clk),
        .g_resetn    (g_resetn),
        .instr_ret   (instr_ret),
        .inhibit_cy  (inhibit_cy),
        .inhibit_ir  (inhibit_ir),
        .ctr_cycle   (ctr_cycle),
        .ctr_instret (ctr_instret)
    );

endmodule

// ==== verification/ccx_timer_tb.sv ====
`timescale 1ns/1ps

`include "ccx_defines.svh"

module ccx_timer_tb;

    localparam int CLK_PERIOD = 100;

    // Cycle budget per test, used by the watchdog.
    localparam int T_RESET  = 8;
    localparam int T_INIT   = 12;
    localparam int T_REGS   = 200 * 6;
    localparam int T_BADOFF = 40 * 6 + 12;
    localparam int T_IRQ    = 120;
    localparam int T_CTR    = 300;
    localparam int T_DROP   = 20;
    localparam int RUN_CYCLES    = T_RESET + T_INIT + T_REGS + T_BADOFF + T_IRQ + T_CTR + T_DROP;
    localparam int MARGIN_CYCLES = 100;

    localparam logic [63:0] MTIMECMP_RST = `CCX_MTIMECMP_RESET;

    logic        f_clk;
    logic        g_resetn;
    logic        host_req;
    logic        host_wen;
    logic [31:0] host_addr;
    logic [31:0] host_wdata;
    logic        host_rsp;
    logic [31:0] host_rdata;
    logic        host_error;
    logic        instr_ret;
    logic        inhibit_cy;
    logic        inhibit_ir;
    logic        timer_interrupt;
    logic [63:0] ctr_time;
    logic [63:0] ctr_cycle;
    logic [63:0] ctr_instret;

    // Reference model state.
    logic [63:0] m_mtime;
    logic [63:0] m_mtimecmp;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;
    logic        m_irq;
    int          m_busy;     // 2 in the BR_ISSUE cycle, 1 in the response cycle.
    logic        m_wen;
    logic [31:0] m_addr;
    logic [31:0] m_wdata;
    logic [31:0] exp_rdata;
    logic        exp_error;

    integer seed;
    int     errors;
    int     checks;
    int     tests;

    ccx_timer_top DUT (
        .f_clk           (f_clk),
        .g_resetn        (g_resetn),
        .host_req        (host_req),
        .host_wen        (host_wen),
        .host_addr       (host_addr),
        .host_wdata      (host_wdata),
        .host_rsp        (host_rsp),
        .host_rdata      (host_rdata),
        .host_error      (host_error),
        .instr_ret       (instr_ret),
        .inhibit_cy      (inhibit_cy),
        .inhibit_ir      (inhibit_ir),
        .timer_interrupt (timer_interrupt),
        .ctr_time        (ctr_time),
        .ctr_cycle       (ctr_cycle),
        .ctr_instret     (ctr_instret)
    );

    initial begin
        f_clk = 1'b0;
        forever #(CLK_PERIOD / 2) f_clk = ~f_clk;
    end

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("ERR %0t ns %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    function automatic logic is_reg_offset(input logic [31:0] off);
        return (off == `CCX_OFF_MTIME_LO) || (off == `CCX_OFF_MTIME_HI) ||
               (off == `CCX_OFF_MTIMECMP_LO) || (off == `CCX_OFF_MTIMECMP_HI);
    endfunction

    // Advance the model over one rising edge, from the inputs held before it.
    task automatic update_model();
        logic [63:0] old_time;
        logic [63:0] old_cmp;
        logic [31:0] off;
        if (!g_resetn) begin
            m_mtime    = '0;
            m_mtimecmp = MTIMECMP_RST;
            m_cycle    = '0;
            m_instret  = '0;
            m_irq      = 1'b0;
            m_busy     = 0;
            exp_rdata  = '0;
            exp_error  = 1'b0;
        end else begin
            old_time = m_mtime;
            old_cmp  = m_mtimecmp;
            off      = (m_addr - `CCX_MMIO_BASE) & (`CCX_MMIO_SIZE - 1);
            m_mtime  = old_time + 64'd1;
            if (m_busy == 2) begin
                exp_rdata = '0;
                exp_error = 1'b0;
                if (off == `CCX_OFF_MTIME_LO) begin
                    exp_rdata = old_time[31:0];
                    if (m_wen) m_mtime = {old_time[63:32], m_wdata};
                end else if (off == `CCX_OFF_MTIME_HI) begin
                    exp_rdata = old_time[63:32];
                    if (m_wen) m_mtime = {m_wdata, old_time[31:0]};
                end else if (off == `CCX_OFF_MTIMECMP_LO) begin
                    exp_rdata = old_cmp[31:0];
                    if (m_wen) m_mtimecmp[31:0] = m_wdata;
                end else if (off == `CCX_OFF_MTIMECMP_HI) begin
                    exp_rdata = old_cmp[63:32];
                    if (m_wen) m_mtimecmp[63:32] = m_wdata;
                end else begin
                    exp_error = 1'b1;
                end
            end
            m_irq = (old_time >= old_cmp); // Seen one cycle late.
            if (!inhibit_cy) m_cycle = m_cycle + 64'd1;
            if (instr_ret && !inhibit_ir) m_instret = m_instret + 64'd1;
            if (m_busy != 0) begin
                m_busy--;
            end else if (host_req) begin
                m_busy  = 2;
                m_wen   = host_wen;
                m_addr  = host_addr;
                m_wdata = host_wdata;
            end
        end
    endtask

    // One clock cycle with all output checks.
    task automatic step();
        @(posedge f_clk);
        update_model();
        #1;
        if (m_busy == 1 && host_rsp !== 1'b1) begin
            errors++;
            $display("At %0t ns no host response came two cycles after the request", $time);
        end else begin
            check_value("host_rsp", m_busy == 1, host_rsp);
        end
        if (m_busy == 1) begin
            check_value("host_rdata", exp_rdata, host_rdata);
            check_value("host_error", exp_error, host_error);
        end
        check_value("ctr_time", m_mtime, ctr_time);
        check_value("timer_interrupt", m_irq, timer_interrupt);
        check_value("ctr_cycle", m_cycle, ctr_cycle);
        check_value("ctr_instret", m_instret, ctr_instret);
    endtask

    task automatic idle(input int n);
        repeat (n) step();
    endtask

    // Strobe, two cycles to the response, one back to idle.
    task automatic host_access(input logic wen, input logic [31:0] off, input logic [31:0] wdata,
                               output logic [31:0] rdata, output logic err);
        host_req   = 1'b1;
        host_wen   = wen;
        host_addr  = `CCX_MMIO_BASE + off;
        host_wdata = wdata;
        step();
        host_req = 1'b0;
        step();
        rdata = host_rdata;
        err   = host_error;
        step();
    endtask

    task automatic test_done(input string name);
        tests++;
        $display("Test %s finished, %0d errors so far", name, errors);
    endtask

    initial begin
        #((RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] off;
        logic [63:0] target;
        logic        err;
        int          irq_cycles;
        int          rsp_count;

        seed       = 32'hc8f25f70;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        g_resetn   = 1'b0;
        host_req   = 1'b0;
        host_wen   = 1'b0;
        host_addr  = '0;
        host_wdata = '0;
        instr_ret  = 1'b0;
        inhibit_cy = 1'b0;
        inhibit_ir = 1'b0;
        m_wen      = 1'b0;
        m_addr     = '0;
        m_wdata    = '0;

        idle(T_RESET);
        check_value("timer_interrupt", 64'd0, timer_interrupt);
        check_value("ctr_time", 64'd0, ctr_time);
        check_value("ctr_cycle", 64'd0, ctr_cycle);
        check_value("ctr_instret", 64'd0, ctr_instret);
        g_resetn = 1'b1;
        host_access(1'b0, `CCX_OFF_MTIMECMP_LO, '0, rd, err);
        check_value("mtimecmp_lo", MTIMECMP_RST[31:0], rd);
        host_access(1'b0, `CCX_OFF_MTIMECMP_HI, '0, rd, err);
        check_value("mtimecmp_hi", MTIMECMP_RST[63:32], rd);
        host_access(1'b0, `CCX_OFF_MTIME_LO, '0, rd, err); // Model predicts the count.
        test_done("reset_state");

        repeat (200) begin
            r = $random(seed);
            host_access(r[4], {28'd0, r[1:0], 2'b00}, $random(seed), rd, err);
            idle(r[9:8]); // Spacing of 3 to 6 cycles.
        end
        test_done("random_access");

        repeat (40) begin
            do begin
                r   = $random(seed);
                off = {24'd0, r[7:0]};
            end while (is_reg_offset(off));
            host_access(r[8], off, $random(seed), rd, err);
            check_value("bad_offset_error", 64'd1, err);
            check_value("bad_offset_rdata", 64'd0, rd);
            idle(r[10:9]);
        end
        host_access(1'b0, `CCX_OFF_MTIMECMP_LO, '0, rd, err);
        host_access(1'b0, `CCX_OFF_MTIMECMP_HI, '0, rd, err);
        test_done("invalid_offset");

        // Park the compare high, then bring mtime near zero.
        host_access(1'b1, `CCX_OFF_MTIMECMP_HI, 32'hffff_ffff, rd, err);
        host_access(1'b1, `CCX_OFF_MTIME_HI, 32'd0, rd, err);
        host_access(1'b1, `CCX_OFF_MTIME_LO, 32'd0, rd, err);
        r      = $random(seed);
        target = m_mtime + 64'd16 + {59'd0, r[4:0]};
        host_access(1'b1, `CCX_OFF_MTIMECMP_LO, target[31:0], rd, err);
        host_access(1'b1, `CCX_OFF_MTIMECMP_HI, target[63:32], rd, err);
        irq_cycles = 0;
        repeat (64) begin
            step();
            if (timer_interrupt === 1'b1) irq_cycles++;
        end
        if (irq_cycles == 0) begin
            errors++;
            $display("The timer interrupt never rose after mtime passed mtimecmp");
        end
        host_access(1'b1, `CCX_OFF_MTIME_LO, 32'd0, rd, err); // Back below the compare.
        idle(8);
        check_value("timer_interrupt", 64'd0, timer_interrupt);
        test_done("timer_interrupt");

        repeat (T_CTR) begin
            r          = $random(seed);
            instr_ret  = r[0];
            inhibit_cy = (r[3:2] == 2'b00);
            inhibit_ir = (r[6:5] == 2'b00);
            step();
        end
        instr_ret  = 1'b0;
        inhibit_cy = 1'b0;
        inhibit_ir = 1'b0;
        test_done("counters");

        // Second strobe lands in BR_ISSUE and must be dropped.
        host_req   = 1'b1;
        host_wen   = 1'b0;
        host_addr  = `CCX_MMIO_BASE + `CCX_OFF_MTIME_HI;
        host_wdata = '0;
        step();
        host_wen   = 1'b1;
        host_addr  = `CCX_MMIO_BASE + `CCX_OFF_MTIME_LO;
        host_wdata = $random(seed);
        step();
        host_req  = 1'b0;
        rsp_count = (host_rsp === 1'b1);
        repeat (6) begin
            step();
            if (host_rsp === 1'b1) rsp_count++;
        end
        check_value("response_count", 64'd1, rsp_count);
        host_access(1'b0, `CCX_OFF_MTIME_LO, '0, rd, err);
        test_done("dropped_strobe");

        $display("Tests: %0d  checks: %0d  errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+design
design/ccx_pkg.sv
design/ccx_memif.sv
design/ccx_mmio_bridge.sv
design/ccx_mmio.sv
design/ccx_counters.sv
design/ccx_timer_top.sv
verification/ccx_timer_tb.sv
